//--- Bender.yml
package:
  name: udp_conn_mgr

sources:
  - files:
      - hw/udp_conn_pkg.sv
      - hw/conn_ifs.sv
      - hw/way_counter.sv
      - hw/conn_table.sv
      - hw/conn_fsm.sv
      - hw/axi_lite_csr.sv
      - hw/udp_conn_mgr_top.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_udp_conn_mgr.sv

//--- hw/axi_lite_csr.sv
`timescale 1ns/10ps

module axi_lite_csr import udp_conn_pkg::*; #(
    parameter int WAYS       = 4,
    parameter int HASH_WIDTH = 4
) (
    input  logic                        s_axi_aclk,
    input  logic                        s_axi_aresetn,
    input  logic [AXI_ADDR_WIDTH-1:0]   s_axi_awaddr,
    input  logic                        s_axi_awvalid,
    output logic                        s_axi_awready,
    input  logic [AXI_DATA_WIDTH-1:0]   s_axi_wdata,
    input  logic [AXI_DATA_WIDTH/8-1:0] s_axi_wstrb,
    input  logic                        s_axi_wvalid,
    output logic                        s_axi_wready,
    output logic [1:0]                  s_axi_bresp,
    output logic                        s_axi_bvalid,
    input  logic                        s_axi_bready,
    input  logic [AXI_ADDR_WIDTH-1:0]   s_axi_araddr,
    input  logic                        s_axi_arvalid,
    output logic                        s_axi_arready,
    output logic [AXI_DATA_WIDTH-1:0]   s_axi_rdata,
    output logic [1:0]                  s_axi_rresp,
    output logic                        s_axi_rvalid,
    input  logic                        s_axi_rready,
    conn_req_if.csr                     req,
    conn_rsp_if.csr                     rsp
);
    localparam int CONN_ID_WIDTH = HASH_WIDTH + $clog2(WAYS);

    logic [IP_ADDR_WIDTH-1:0]  ip_addr_q;
    logic [UDP_PORT_WIDTH-1:0] udp_port_q;
    conn_op_e                  op_q;
    logic                      ack_q;
    logic                      full_q;
    logic                      done_q;
    logic [CONN_ID_WIDTH-1:0]  conn_id_q;
    logic [AXI_DATA_WIDTH-1:0] wmask;
    logic [AXI_DATA_WIDTH-1:0] rd_mux;
    logic                      wr_go;
    logic                      wr_fire;
    logic                      rd_fire;
    logic                      trigger;
    logic                      issue;

    assign s_axi_bresp = 2'b00;
    assign s_axi_rresp = 2'b00;

    // --------------------
    // Write channel
    // --------------------
    assign wr_go   = !s_axi_awready && s_axi_awvalid && s_axi_wvalid && !s_axi_bvalid;
    assign wr_fire = s_axi_awready && s_axi_wready && s_axi_awvalid && s_axi_wvalid;

    always_comb begin
        for (int i = 0; i < AXI_DATA_WIDTH / 8; i++) begin
            wmask[i*8 +: 8] = {8{s_axi_wstrb[i]}};
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            s_axi_awready <= 1'b0;
            s_axi_wready  <= 1'b0;
            s_axi_bvalid  <= 1'b0;
        end else begin
            s_axi_awready <= wr_go;
            s_axi_wready  <= wr_go;
            if (wr_fire) begin
                s_axi_bvalid <= 1'b1;
            end else if (s_axi_bready) begin
                s_axi_bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            ip_addr_q  <= '0;
            udp_port_q <= '0;
            op_q       <= OP_UNBIND;
        end else if (wr_fire) begin
            case (s_axi_awaddr)
                REG_IP_ADDR: ip_addr_q <= (ip_addr_q & ~wmask) | (s_axi_wdata & wmask);
                REG_PORT: begin
                    udp_port_q <= (udp_port_q & ~wmask[UDP_PORT_WIDTH-1:0])
                                | (s_axi_wdata[UDP_PORT_WIDTH-1:0] & wmask[UDP_PORT_WIDTH-1:0]);
                end
                REG_OP: begin
                    if (s_axi_wstrb[0]) begin
                        op_q <= conn_op_e'(s_axi_wdata[0]);
                    end
                end
                default: ;
            endcase
        end
    end

    // --------------------
    // Trigger and request
    // --------------------
    // Busy manager drops the trigger
    assign trigger = wr_fire && s_axi_awaddr == REG_TRIGGER && s_axi_wstrb[0] && s_axi_wdata[0];
    assign issue   = trigger && req.ready;

    assign req.op       = op_q;
    assign req.ip_addr  = ip_addr_q;
    assign req.udp_port = udp_port_q;

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            req.valid <= 1'b0;
        end else begin
            req.valid <= issue;
        end
    end

    // Response capture, cleared by each new request
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            ack_q     <= 1'b0;
            full_q    <= 1'b0;
            done_q    <= 1'b0;
            conn_id_q <= '0;
        end else if (rsp.valid) begin
            ack_q     <= rsp.ack;
            full_q    <= rsp.full;
            done_q    <= 1'b1;
            conn_id_q <= rsp.conn_id;
        end else if (issue) begin
            ack_q     <= 1'b0;
            full_q    <= 1'b0;
            done_q    <= 1'b0;
            conn_id_q <= '0;
        end
    end

    // --------------------
    // Read channel
    // --------------------
    assign rd_fire = s_axi_arready && s_axi_arvalid;

    always_comb begin
        rd_mux = '0;
        case (s_axi_araddr)
            REG_IP_ADDR: rd_mux = ip_addr_q;
            REG_PORT:    rd_mux = AXI_DATA_WIDTH'(udp_port_q);
            REG_OP:      rd_mux = AXI_DATA_WIDTH'(op_q);
            REG_STATUS: begin
                rd_mux[STATUS_ACK_BIT]  = ack_q;
                rd_mux[STATUS_FULL_BIT] = full_q;
                rd_mux[STATUS_DONE_BIT] = done_q;
            end
            REG_CONN_ID: rd_mux = AXI_DATA_WIDTH'(conn_id_q);
            default:     rd_mux = '0;
        endcase
    end

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            s_axi_arready <= 1'b0;
            s_axi_rvalid  <= 1'b0;
            s_axi_rdata   <= '0;
        end else begin
            s_axi_arready <= !s_axi_arready && s_axi_arvalid && !s_axi_rvalid;
            if (rd_fire) begin
                s_axi_rvalid <= 1'b1;
                s_axi_rdata  <= rd_mux;
            end else if (s_axi_rready) begin
                s_axi_rvalid <= 1'b0;
            end
        end
    end

endmodule

//--- hw/conn_fsm.sv
`timescale 1ns/10ps

module conn_fsm import udp_conn_pkg::*; #(
    parameter int WAYS       = 4,
    parameter int HASH_WIDTH = 4
) (
    input  logic                     s_axi_aclk,
    input  logic                     s_axi_aresetn,
    conn_req_if.fsm                  req,
    conn_rsp_if.fsm                  rsp,
    table_if.fsm                     tbl,
    output logic                     way_clear,
    output logic                     way_step,
    input  logic [$clog2(WAYS)-1:0]  way,
    input  logic                     way_last
);
    localparam int WAY_WIDTH     = $clog2(WAYS);
    localparam int CONN_ID_WIDTH = HASH_WIDTH + WAY_WIDTH;

    cm_state_e                 state_q;
    logic [IP_ADDR_WIDTH-1:0]  key_ip_q;
    logic [UDP_PORT_WIDTH-1:0] key_port_q;
    conn_op_e                  key_op_q;
    logic [HASH_WIDTH-1:0]     set_q;
    logic [15:0]               req_hash;
    logic                      take;
    logic                      match;
    logic                      hit_q;
    logic                      free_q;
    logic [WAY_WIDTH-1:0]      hit_way_q;
    logic [WAY_WIDTH-1:0]      free_way_q;
    logic [WAY_WIDTH-1:0]      tgt_way;
    logic                      do_write;
    logic                      ack_next;
    logic                      ack_q;
    logic                      full_q;
    logic [CONN_ID_WIDTH-1:0]  id_q;

    // Set index times WAYS plus way
    function automatic logic [CONN_ID_WIDTH-1:0] make_id(
        input logic [HASH_WIDTH-1:0] set_idx,
        input logic [WAY_WIDTH-1:0]  way_idx
    );
        return CONN_ID_WIDTH'(set_idx) * CONN_ID_WIDTH'(WAYS) + CONN_ID_WIDTH'(way_idx);
    endfunction

    assign take     = req.valid && req.ready;
    assign req_hash = hash_ip_port(req.ip_addr, req.udp_port);
    assign match    = tbl.rd_valid && tbl.rd_ip_addr == key_ip_q && tbl.rd_udp_port == key_port_q;

    // Bind goes to the first free way unless already bound
    assign tgt_way  = (key_op_q == OP_BIND && !hit_q) ? free_way_q : hit_way_q;
    assign do_write = (key_op_q == OP_BIND) ? (!hit_q && free_q) : hit_q;
    assign ack_next = (key_op_q == OP_BIND) ? (hit_q || free_q) : hit_q;

    assign req.ready   = state_q == ST_IDLE;
    assign rsp.valid   = state_q == ST_RESPOND;
    assign rsp.ack     = ack_q;
    assign rsp.full    = full_q;
    assign rsp.conn_id = id_q;

    assign way_clear = take;
    assign way_step  = state_q == ST_CHECK && !way_last;

    assign tbl.rd_en       = state_q == ST_READ;
    assign tbl.wr_en       = state_q == ST_WRITE && do_write;
    assign tbl.addr        = (state_q == ST_WRITE) ? make_id(set_q, tgt_way) : make_id(set_q, way);
    assign tbl.wr_valid    = key_op_q == OP_BIND;
    assign tbl.wr_ip_addr  = key_ip_q;
    assign tbl.wr_udp_port = key_port_q;

    // --------------------
    // State register
    // --------------------
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE:    state_q <= take ? ST_READ : ST_IDLE;
                ST_READ:    state_q <= ST_CHECK;
                ST_CHECK:   state_q <= way_last ? ST_WRITE : ST_READ;
                ST_WRITE:   state_q <= ST_RESPOND;
                ST_RESPOND: state_q <= ST_IDLE;
                default:    state_q <= ST_IDLE;
            endcase
        end
    end

    // --------------------
    // Key, probe tracking, result
    // --------------------
    always_ff @(posedge s_axi_aclk) begin
        if (take) begin
            key_ip_q   <= req.ip_addr;
            key_port_q <= req.udp_port;
            key_op_q   <= req.op;
            set_q      <= req_hash[HASH_WIDTH-1:0];
            hit_q      <= 1'b0;
            free_q     <= 1'b0;
        end
        if (state_q == ST_CHECK) begin
            if (match && !hit_q) begin
                hit_q     <= 1'b1;
                hit_way_q <= way;
            end
            // Lowest empty way wins
            if (!tbl.rd_valid && !free_q) begin
                free_q     <= 1'b1;
                free_way_q <= way;
            end
        end
        if (state_q == ST_WRITE) begin
            ack_q  <= ack_next;
            full_q <= key_op_q == OP_BIND && !ack_next;
            id_q   <= ack_next ? make_id(set_q, tgt_way) : '0;
        end
    end

endmodule

//--- hw/conn_ifs.sv
`timescale 1ns/10ps

// Connection request from the register block
interface conn_req_if import udp_conn_pkg::*; ();
    logic                      valid;
    conn_op_e                  op;
    logic [IP_ADDR_WIDTH-1:0]  ip_addr;
    logic [UDP_PORT_WIDTH-1:0] udp_port;
    logic                      ready;

    modport csr (output valid, op, ip_addr, udp_port, input ready);
    modport fsm (input valid, op, ip_addr, udp_port, output ready);
endinterface

// Outcome of one request, single pulse
interface conn_rsp_if #(
    parameter int WAYS       = 4,
    parameter int HASH_WIDTH = 4
) ();
    localparam int CONN_ID_WIDTH = HASH_WIDTH + $clog2(WAYS);

    logic                     valid;
    logic                     ack;
    logic                     full;
    logic [CONN_ID_WIDTH-1:0] conn_id;

    modport fsm (output valid, ack, full, conn_id);
    modport csr (input valid, ack, full, conn_id);
endinterface

// Connection table port, addressed by connection id
interface table_if import udp_conn_pkg::*; #(
    parameter int WAYS       = 4,
    parameter int HASH_WIDTH = 4
) ();
    localparam int CONN_ID_WIDTH = HASH_WIDTH + $clog2(WAYS);

    logic                      rd_en;
    logic                      wr_en;
    logic [CONN_ID_WIDTH-1:0]  addr;
    logic                      wr_valid;
    logic [IP_ADDR_WIDTH-1:0]  wr_ip_addr;
    logic [UDP_PORT_WIDTH-1:0] wr_udp_port;
    logic                      rd_valid;
    logic [IP_ADDR_WIDTH-1:0]  rd_ip_addr;
    logic [UDP_PORT_WIDTH-1:0] rd_udp_port;

    modport fsm (
        output rd_en, wr_en, addr, wr_valid, wr_ip_addr, wr_udp_port,
        input  rd_valid, rd_ip_addr, rd_udp_port
    );
    modport storage (
        input  rd_en, wr_en, addr, wr_valid, wr_ip_addr, wr_udp_port,
        output rd_valid, rd_ip_addr, rd_udp_port
    );
endinterface

//--- hw/conn_table.sv
`timescale 1ns/10ps

module conn_table import udp_conn_pkg::*; #(
    parameter int WAYS       = 4,
    parameter int HASH_WIDTH = 4
) (
    input  logic       s_axi_aclk,
    input  logic       s_axi_aresetn,
    table_if.storage   tbl
);
    localparam int DEPTH = (2 ** HASH_WIDTH) * WAYS;

    logic [IP_ADDR_WIDTH-1:0]  ip_mem   [DEPTH];
    logic [UDP_PORT_WIDTH-1:0] port_mem [DEPTH];
    logic [DEPTH-1:0]          valid_q;

    // Key storage
    always_ff @(posedge s_axi_aclk) begin
        if (tbl.wr_en) begin
            ip_mem[tbl.addr]   <= tbl.wr_ip_addr;
            port_mem[tbl.addr] <= tbl.wr_udp_port;
        end
        if (tbl.rd_en) begin
            tbl.rd_ip_addr  <= ip_mem[tbl.addr];
            tbl.rd_udp_port <= port_mem[tbl.addr];
        end
    end

    // Entry valid bits, all invalid out of reset
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            valid_q      <= '0;
            tbl.rd_valid <= 1'b0;
        end else begin
            if (tbl.wr_en) begin
                valid_q[tbl.addr] <= tbl.wr_valid;
            end
            if (tbl.rd_en) begin
                tbl.rd_valid <= valid_q[tbl.addr];
            end
        end
    end

endmodule

//--- hw/udp_conn_mgr_top.sv
`timescale 1ns/10ps

module udp_conn_mgr_top import udp_conn_pkg::*; #(
    parameter int WAYS       = 4,
    parameter int HASH_WIDTH = 4
) (
    input  logic                        s_axi_aclk,
    input  logic                        s_axi_aresetn,
    input  logic [AXI_ADDR_WIDTH-1:0]   s_axi_awaddr,
    input  logic [2:0]                  s_axi_awprot,
    input  logic                        s_axi_awvalid,
    output logic                        s_axi_awready,
    input  logic [AXI_DATA_WIDTH-1:0]   s_axi_wdata,
    input  logic [AXI_DATA_WIDTH/8-1:0] s_axi_wstrb,
    input  logic                        s_axi_wvalid,
    output logic                        s_axi_wready,
    output logic [1:0]                  s_axi_bresp,
    output logic                        s_axi_bvalid,
    input  logic                        s_axi_bready,
    input  logic [AXI_ADDR_WIDTH-1:0]   s_axi_araddr,
    input  logic [2:0]                  s_axi_arprot,
    input  logic                        s_axi_arvalid,
    output logic                        s_axi_arready,
    output logic [AXI_DATA_WIDTH-1:0]   s_axi_rdata,
    output logic [1:0]                  s_axi_rresp,
    output logic                        s_axi_rvalid,
    input  logic                        s_axi_rready
);
    // Protection bits carry no meaning for this register map
    logic [$clog2(WAYS)-1:0] way;
    logic                    way_clear;
    logic                    way_step;
    logic                    way_last;

    conn_req_if                                          req_if ();
    conn_rsp_if #(.WAYS(WAYS), .HASH_WIDTH(HASH_WIDTH))  rsp_if ();
    table_if    #(.WAYS(WAYS), .HASH_WIDTH(HASH_WIDTH))  tbl_if ();

    // --------------------
    // Register block
    // --------------------
    axi_lite_csr #(
        .WAYS       (WAYS),
        .HASH_WIDTH (HASH_WIDTH)
    ) csr_i (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .req           (req_if.csr),
        .rsp           (rsp_if.csr)
    );

    // --------------------
    // Connection manager
    // --------------------
    conn_fsm #(
        .WAYS       (WAYS),
        .HASH_WIDTH (HASH_WIDTH)
    ) fsm_i (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .req           (req_if.fsm),
        .rsp           (rsp_if.fsm),
        .tbl           (tbl_if.fsm),
        .way_clear     (way_clear),
        .way_step      (way_step),
        .way           (way),
        .way_last      (way_last)
    );

    way_counter #(
        .WAYS (WAYS)
    ) way_cnt_i (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .clear         (way_clear),
        .step          (way_step),
        .way           (way),
        .last          (way_last)
    );

    conn_table #(
        .WAYS       (WAYS),
        .HASH_WIDTH (HASH_WIDTH)
    ) table_i (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .tbl           (tbl_if.storage)
    );

endmodule

//--- hw/udp_conn_pkg.sv
package udp_conn_pkg;

    parameter int IP_ADDR_WIDTH  = 32;
    parameter int UDP_PORT_WIDTH = 16;
    parameter int AXI_DATA_WIDTH = 32;
    parameter int AXI_ADDR_WIDTH = 7;

    // Register byte offsets
    typedef enum logic [AXI_ADDR_WIDTH-1:0] {
        REG_IP_ADDR = 7'h00,
        REG_PORT    = 7'h04,
        REG_OP      = 7'h08,
        REG_TRIGGER = 7'h0C,
        REG_STATUS  = 7'h10,
        REG_CONN_ID = 7'h14
    } csr_addr_e;

    parameter int STATUS_ACK_BIT  = 0;
    parameter int STATUS_FULL_BIT = 1;
    parameter int STATUS_DONE_BIT = 2;

    typedef enum logic {
        OP_UNBIND = 1'b0,
        OP_BIND   = 1'b1
    } conn_op_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ,
        ST_CHECK,
        ST_WRITE,
        ST_RESPOND
    } cm_state_e;

    // Fold the 48-bit key to 32 bits, then multiplicative hash
    function automatic logic [15:0] hash_ip_port(
        input logic [IP_ADDR_WIDTH-1:0]  ip_addr,
        input logic [UDP_PORT_WIDTH-1:0] udp_port
    );
        logic [47:0] key;
        logic [31:0] mix;
        key = {ip_addr, udp_port};
        mix = key[31:0] ^ {key[47:32], key[15:0]};
        mix = mix * 32'h9E3779B1;
        return mix[31:16];
    endfunction

endpackage

//--- hw/way_counter.sv
`timescale 1ns/10ps

module way_counter #(
    parameter int WAYS = 4
) (
    input  logic                    s_axi_aclk,
    input  logic                    s_axi_aresetn,
    input  logic                    clear,
    input  logic                    step,
    output logic [$clog2(WAYS)-1:0] way,
    output logic                    last
);
    localparam int WAY_WIDTH = $clog2(WAYS);

    assign last = way == WAY_WIDTH'(WAYS - 1);

    // Wraps back to way 0 after the final way
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn || clear) begin
            way <= '0;
        end else if (step) begin
            way <= last ? '0 : way + 1'b1;
        end
    end

endmodule

//--- udp_conn_mgr_top.f
hw/udp_conn_pkg.sv
hw/conn_ifs.sv
hw/way_counter.sv
hw/conn_table.sv
hw/conn_fsm.sv
hw/axi_lite_csr.sv
hw/udp_conn_mgr_top.sv
verif/tb_clk_gen.sv
verif/tb_udp_conn_mgr.sv

//--- verif/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic s_axi_aclk,
    output logic s_axi_aresetn
);
    initial begin
        s_axi_aclk = 1'b0;
        forever #(PERIOD_NS / 2) s_axi_aclk = ~s_axi_aclk;
    end

    // Release lands just after an edge, like the other inputs
    initial begin
        s_axi_aresetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge s_axi_aclk);
        #1 s_axi_aresetn = 1'b1;
    end
endmodule

//--- verif/tb_udp_conn_mgr.sv
`timescale 1ns/10ps

module tb_udp_conn_mgr import udp_conn_pkg::*; ();

    localparam int WAYS           = 4;
    localparam int HASH_WIDTH     = 4;
    localparam int NUM_SETS       = 2 ** HASH_WIDTH;
    localparam int NUM_NEW        = 8;
    localparam int NUM_RANDOM     = 200;
    localparam int POOL_SIZE      = 40;
    localparam int NUM_OPS        = 8 + NUM_NEW + 2 + (WAYS + 1) + 3 + NUM_RANDOM;
    localparam int TIMEOUT_CYCLES = 60 * NUM_OPS;

    logic        s_axi_aclk;
    logic        s_axi_aresetn;
    logic [6:0]  s_axi_awaddr;
    logic [2:0]  s_axi_awprot;
    logic        s_axi_awvalid;
    logic        s_axi_awready;
    logic [31:0] s_axi_wdata;
    logic [3:0]  s_axi_wstrb;
    logic        s_axi_wvalid;
    logic        s_axi_wready;
    logic [1:0]  s_axi_bresp;
    logic        s_axi_bvalid;
    logic        s_axi_bready;
    logic [6:0]  s_axi_araddr;
    logic [2:0]  s_axi_arprot;
    logic        s_axi_arvalid;
    logic        s_axi_arready;
    logic [31:0] s_axi_rdata;
    logic [1:0]  s_axi_rresp;
    logic        s_axi_rvalid;
    logic        s_axi_rready;

    int          err_cnt   = 0;
    int          check_cnt = 0;
    int          cycle_cnt = 0;
    logic [31:0] rng_state;

    // Reference table, one row of ways per set
    logic        model_valid [NUM_SETS][WAYS];
    logic [31:0] model_ip    [NUM_SETS][WAYS];
    logic [15:0] model_port  [NUM_SETS][WAYS];
    logic [31:0] pool_ip     [POOL_SIZE];
    logic [15:0] pool_port   [POOL_SIZE];

    tb_clk_gen #(.PERIOD_NS(20), .RESET_CYCLES(2)) clk_gen_i (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn)
    );

    udp_conn_mgr_top #(
        .WAYS       (WAYS),
        .HASH_WIDTH (HASH_WIDTH)
    ) dut_i (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awprot  (s_axi_awprot),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arprot  (s_axi_arprot),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready)
    );

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    // Fold of the 48-bit key, then the golden-ratio multiply
    function automatic logic [15:0] model_hash(input logic [31:0] ip, input logic [15:0] port);
        logic [47:0] key;
        logic [31:0] folded;
        logic [63:0] product;
        key     = {ip, port};
        folded  = key[31:0] ^ {key[47:32], key[15:0]};
        product = 64'(folded) * 64'h9E37_79B1;
        return product[31:16];
    endfunction

    function automatic int model_set(input logic [31:0] ip, input logic [15:0] port);
        return int'(model_hash(ip, port)) % NUM_SETS;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        check_cnt++;
        if (actual !== expected) begin
            err_cnt++;
            $display("Mismatch at %0t: %s, got 0x%08h, expected 0x%08h",
                     $time, msg, actual, expected);
        end
    endtask

    task automatic tick();
        @(posedge s_axi_aclk);
        #1;
    endtask

    task automatic axi_write(input logic [6:0] addr, input logic [31:0] data);
        s_axi_awaddr  = addr;
        s_axi_wdata   = data;
        s_axi_wstrb   = 4'hF;
        s_axi_awvalid = 1'b1;
        s_axi_wvalid  = 1'b1;
        tick();
        while (!s_axi_awready) tick();
        // Handshake happens on the next edge
        tick();
        s_axi_awvalid = 1'b0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b1;
        while (!s_axi_bvalid) tick();
        check_value(32'(s_axi_bresp), 32'h0, "bresp");
        tick();
        s_axi_bready = 1'b0;
    endtask

    task automatic axi_read(input logic [6:0] addr, output logic [31:0] data);
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        tick();
        while (!s_axi_arready) tick();
        tick();
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b1;
        while (!s_axi_rvalid) tick();
        data = s_axi_rdata;
        check_value(32'(s_axi_rresp), 32'h0, "rresp");
        tick();
        s_axi_rready = 1'b0;
    endtask

    // Expected status and id, table updated as the probe would
    task automatic model_apply(input conn_op_e op, input logic [31:0] ip,
                               input logic [15:0] port,
                               output logic [31:0] status, output logic [31:0] id);
        int set_idx;
        int hit_way;
        int free_way;
        set_idx  = model_set(ip, port);
        hit_way  = -1;
        free_way = -1;
        for (int w = 0; w < WAYS; w++) begin
            if (model_valid[set_idx][w] && model_ip[set_idx][w] == ip
                    && model_port[set_idx][w] == port && hit_way < 0) begin
                hit_way = w;
            end
            if (!model_valid[set_idx][w] && free_way < 0) begin
                free_way = w;
            end
        end
        status = 32'h1 << STATUS_DONE_BIT;
        id     = '0;
        if (hit_way >= 0) begin
            status[STATUS_ACK_BIT] = 1'b1;
            id = set_idx * WAYS + hit_way;
            if (op == OP_UNBIND) begin
                model_valid[set_idx][hit_way] = 1'b0;
            end
        end else if (op == OP_BIND && free_way >= 0) begin
            model_valid[set_idx][free_way] = 1'b1;
            model_ip[set_idx][free_way]    = ip;
            model_port[set_idx][free_way]  = port;
            status[STATUS_ACK_BIT] = 1'b1;
            id = set_idx * WAYS + free_way;
        end else if (op == OP_BIND) begin
            status[STATUS_FULL_BIT] = 1'b1;
        end
    endtask

    // One request through the register map, checked against the model
    task automatic run_op(input conn_op_e op, input logic [31:0] ip, input logic [15:0] port,
                          input string tag,
                          output logic [31:0] status, output logic [31:0] id);
        logic [31:0] exp_status;
        logic [31:0] exp_id;
        model_apply(op, ip, port, exp_status, exp_id);
        axi_write(REG_IP_ADDR, ip);
        axi_write(REG_PORT, {16'h0, port});
        axi_write(REG_OP, {31'h0, op});
        axi_write(REG_TRIGGER, 32'h1);
        status = '0;
        while (!status[STATUS_DONE_BIT]) axi_read(REG_STATUS, status);
        axi_read(REG_CONN_ID, id);
        check_value(status, exp_status, {tag, " status"});
        check_value(id, exp_id, {tag, " conn id"});
    endtask

    task automatic find_key(input int set_idx, output logic [31:0] ip,
                            output logic [15:0] port);
        logic [31:0] rnd;
        int          tries;
        tries = 0;
        do begin
            ip   = lcg_next();
            rnd  = lcg_next();
            port = rnd[31:16];
            tries++;
        end while (model_set(ip, port) != set_idx && tries < 100000);
        if (model_set(ip, port) != set_idx) begin
            err_cnt++;
            $display("No random key found that hashes to set %0d", set_idx);
        end
    endtask

    // --------------------
    // Watchdog
    // --------------------
    always @(posedge s_axi_aclk) cycle_cnt <= cycle_cnt + 1;

    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    // --------------------
    // Stimulus
    // --------------------
    initial begin
        logic [31:0] rdata;
        logic [31:0] wval;
        logic [31:0] rnd;
        logic [31:0] status;
        logic [31:0] id;
        logic [31:0] first_id;
        logic [31:0] first_ip;
        logic [15:0] first_port;
        logic [31:0] ip;
        logic [15:0] port;
        logic [31:0] set_ip   [WAYS+1];
        logic [15:0] set_port [WAYS+1];
        logic        set_empty;
        int          target_set;
        conn_op_e    op;

        s_axi_awaddr  = '0;
        s_axi_awprot  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arprot  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        rng_state     = 32'd33;
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < WAYS; w++) begin
                model_valid[s][w] = 1'b0;
            end
        end
        wait (s_axi_aresetn);
        tick();

        // Register readback and unmapped offsets
        wval = lcg_next();
        axi_write(REG_IP_ADDR, wval);
        axi_read(REG_IP_ADDR, rdata);
        check_value(rdata, wval, "IP address readback");
        wval = lcg_next();
        axi_write(REG_PORT, wval);
        axi_read(REG_PORT, rdata);
        check_value(rdata, {16'h0, wval[15:0]}, "port readback");
        axi_write(REG_OP, 32'h1);
        axi_read(REG_OP, rdata);
        check_value(rdata, 32'h1, "op readback");
        axi_read(REG_STATUS, rdata);
        check_value(rdata, 32'h0, "status after reset");
        axi_read(7'h18, rdata);
        check_value(rdata, 32'h0, "unmapped read 0x18");
        axi_read(7'h7C, rdata);
        check_value(rdata, 32'h0, "unmapped read 0x7C");

        // Fresh binds
        for (int n = 0; n < NUM_NEW; n++) begin
            ip  = lcg_next();
            rnd = lcg_next();
            run_op(OP_BIND, ip, rnd[31:16], "new bind", status, id);
            check_value(status, (32'h1 << STATUS_ACK_BIT) | (32'h1 << STATUS_DONE_BIT),
                        "new bind ack");
            if (n == 0) begin
                first_ip   = ip;
                first_port = rnd[31:16];
                // Empty table, so the first bind lands on way 0
                first_id   = model_set(ip, rnd[31:16]) * WAYS;
            end
        end

        // Repeat bind must not take a second way
        run_op(OP_BIND, first_ip, first_port, "repeat bind", status, id);
        check_value(id, first_id, "repeat bind keeps id");
        find_key(model_set(first_ip, first_port), ip, port);
        run_op(OP_BIND, ip, port, "bind after repeat", status, id);

        // Fill one empty set, then overflow it
        target_set = -1;
        for (int s = 0; s < NUM_SETS; s++) begin
            set_empty = 1'b1;
            for (int w = 0; w < WAYS; w++) begin
                if (model_valid[s][w]) begin
                    set_empty = 1'b0;
                end
            end
            if (target_set < 0 && set_empty) begin
                target_set = s;
            end
        end
        if (target_set < 0) begin
            err_cnt++;
            $display("No empty set left for the full-set test");
        end else begin
            for (int k = 0; k <= WAYS; k++) begin
                find_key(target_set, set_ip[k], set_port[k]);
            end
            for (int k = 0; k < WAYS; k++) begin
                run_op(OP_BIND, set_ip[k], set_port[k], "fill set", status, id);
                check_value(id, target_set * WAYS + k, "fill set way");
            end
            run_op(OP_BIND, set_ip[WAYS], set_port[WAYS], "bind to full set", status, id);
            check_value(status, (32'h1 << STATUS_FULL_BIT) | (32'h1 << STATUS_DONE_BIT),
                        "full set status");
            check_value(id, 32'h0, "full set id");

            // Unbind frees way 1 for the next bind
            run_op(OP_UNBIND, set_ip[1], set_port[1], "unbind", status, id);
            check_value(id, target_set * WAYS + 1, "unbind id");
            run_op(OP_BIND, set_ip[WAYS], set_port[WAYS], "bind after unbind", status, id);
            check_value(id, target_set * WAYS + 1, "reused way id");
        end
        ip  = lcg_next();
        rnd = lcg_next();
        run_op(OP_UNBIND, ip, rnd[31:16], "unbind absent", status, id);
        check_value(status, 32'h1 << STATUS_DONE_BIT, "unbind absent status");

        // Random mix over a small key pool
        for (int p = 0; p < POOL_SIZE; p++) begin
            pool_ip[p] = lcg_next();
            rnd        = lcg_next();
            pool_port[p] = rnd[31:16];
        end
        for (int n = 0; n < NUM_RANDOM; n++) begin
            rnd = lcg_next();
            op  = (rnd[31:24] < 8'd154) ? OP_BIND : OP_UNBIND;
            rnd = lcg_next();
            run_op(op, pool_ip[rnd[31:16] % POOL_SIZE], pool_port[rnd[31:16] % POOL_SIZE],
                   "random op", status, id);
        end

        $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
